// ==== Makefile ====
# Verilator build and run for the image gradient engine

SRCS := $(wildcard verilog/*.sv verification/*.sv)

.PHONY: all run clean

all: obj_dir/Vig_tb

# rebuilt only when a source or the file list changes
obj_dir/Vig_tb: ig.f $(SRCS)
	verilator --binary --timing --assert --top-module ig_tb -f ig.f -Mdir obj_dir -o Vig_tb

# exit status of the simulator is the test result
run: obj_dir/Vig_tb
	./obj_dir/Vig_tb

clean:
	rm -rf obj_dir

// ==== ig.f ====
verilog/ig_pkg.sv
verilog/ig_fetch.sv
verilog/ig_line_buffer.sv
verilog/ig_gradient.sv
verilog/ig_writeback.sv
verilog/ig_top.sv
verification/ig_assertions.sv
verification/ig_tb.sv

// ==== verification/ig_assertions.sv ====
`timescale 1ns/1ps

module ig_assertions import ig_pkg::*; (
    input logic  clk,
    input logic  reset,
    input logic  img_rd,
    input addr_t img_addr,
    input logic  grad_wr,
    input logic  grad_ready,
    input addr_t grad_addr,
    input grad_t grad_do,
    input logic  done
);

    logic  read_seen;
    addr_t last_read_addr;

    // ----------------------------------------
    // read address tracking
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            read_seen <= 1'b0;
        end else if (img_rd) begin
            read_seen <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (img_rd) begin
            last_read_addr <= img_addr;
        end
    end

    // ----------------------------------------
    // port protocol
    // ----------------------------------------
    // first reset edge clears the flops, checked from the second on
    a_quiet_in_reset: assert property (@(posedge clk)
        (reset && $past(reset)) |-> (!img_rd && !grad_wr))
        else $error("img_rd or grad_wr high during reset");

    a_write_stable: assert property (@(posedge clk) disable iff (reset)
        (grad_wr && !grad_ready) |=> (grad_wr && $stable(grad_addr) && $stable(grad_do)))
        else $error("stalled gradient write changed before acceptance");

    a_done_sticky: assert property (@(posedge clk) disable iff (reset)
        done |=> done)
        else $error("done fell without reset");

    a_read_first: assert property (@(posedge clk) disable iff (reset)
        (img_rd && !read_seen) |-> (img_addr == '0))
        else $error("first image read after reset not at address 0");

    a_read_step: assert property (@(posedge clk) disable iff (reset)
        (img_rd && read_seen) |-> (img_addr == addr_t'(last_read_addr + 16'd1)))
        else $error("image read address did not advance by one");

endmodule

bind ig_top ig_assertions u_assertions (
    .clk        (clk),
    .reset      (reset),
    .img_rd     (img_rd),
    .img_addr   (img_addr),
    .grad_wr    (grad_wr),
    .grad_ready (grad_ready),
    .grad_addr  (grad_addr),
    .grad_do    (grad_do),
    .done       (done)
);

// ==== verification/ig_tb.sv ====
`timescale 1ns/1ps

module ig_tb import ig_pkg::*; ();

    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 5;
    localparam int DRAIN_CYCLES    = 200;
    localparam int WATCHDOG_CYCLES = 2 * (NPIX + IMG_W) * 4 + 2000;

    logic   clk        = 1'b0;
    logic   reset      = 1'b1;
    pixel_t img_di     = '0;
    logic   grad_ready = 1'b0;
    logic   img_rd;
    addr_t  img_addr;
    logic   grad_wr;
    addr_t  grad_addr;
    grad_t  grad_do;
    logic   done;

    pixel_t img_mem [0:NPIX-1];
    int     seed;
    logic   rd_seen;
    addr_t  rd_addr_q;
    int     n_reads;
    int     n_writes;

    ig_top u_dut (
        .clk        (clk),
        .reset      (reset),
        .img_di     (img_di),
        .grad_ready (grad_ready),
        .img_rd     (img_rd),
        .img_addr   (img_addr),
        .grad_wr    (grad_wr),
        .grad_addr  (grad_addr),
        .grad_do    (grad_do),
        .done       (done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ----------------------------------------
    // failure reporting and compares
    // ----------------------------------------
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_grad(input string name, input grad_t got, input grad_t exp);
        if (got !== exp) begin
            stop_run($sformatf("** Error at %0t: %s = gx %0d gy %0d, expected gx %0d gy %0d",
                $time, name, got.gx, got.gy, exp.gx, exp.gy));
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            stop_run($sformatf("** Error at %0t: %s = %0d, expected %0d",
                $time, name, got, exp));
        end
    endtask

    task automatic check_done(input string name, input bit got, input bit exp);
        if (got !== exp) begin
            stop_run($sformatf("** Error at %0t: %s = %0b, expected %0b",
                $time, name, got, exp));
        end
    endtask

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    // forward differences with the last column and last row forced to zero
    function automatic grad_t expected_grad(input addr_t a);
        int    x;
        int    y;
        int    dx;
        int    dy;
        grad_t g;
        x  = int'(a) % IMG_W;
        y  = int'(a) / IMG_W;
        dx = 0;
        dy = 0;
        if (x != IMG_W - 1) begin
            dx = int'(img_mem[addr_t'(int'(a) + 1)]) - int'(img_mem[a]);
        end
        if (y != IMG_H - 1) begin
            dy = int'(img_mem[addr_t'(int'(a) + IMG_W)]) - int'(img_mem[a]);
        end
        g.gx = grad_comp_t'(dx);
        g.gy = grad_comp_t'(dy);
        return g;
    endfunction

    task automatic fill_random_image();
        for (int i = 0; i < NPIX; i++) begin
            img_mem[addr_t'(i)] = pixel_t'($random(seed));
        end
    endtask

    // x + 2y wrapping modulo 256 further down the image
    task automatic fill_ramp_image();
        for (int y = 0; y < IMG_H; y++) begin
            for (int x = 0; x < IMG_W; x++) begin
                img_mem[addr_t'(y * IMG_W + x)] = pixel_t'(x + 2 * y);
            end
        end
    endtask

    // ----------------------------------------
    // memory models
    // ----------------------------------------
    // read data and stall pattern change 1 ns after the edge
    always @(posedge clk) begin
        #1;
        if (rd_seen) begin
            img_di = img_mem[rd_addr_q];
        end
        grad_ready = ($unsigned($random(seed)) % 100) < 70;
    end

    // port monitor on the falling edge
    always @(negedge clk) begin
        rd_seen = 1'b0;
        if (reset) begin
            n_reads  = 0;
            n_writes = 0;
        end else begin
            check_done("done", done, n_writes == NPIX);
            if (img_rd) begin
                if (n_reads >= NPIX) begin
                    stop_run("image read issued after the whole image was read");
                end
                check_addr("img_addr", img_addr, addr_t'(n_reads));
                rd_seen   = 1'b1;
                rd_addr_q = img_addr;
                n_reads++;
            end
            if (grad_wr && grad_ready) begin
                if (n_writes >= NPIX) begin
                    stop_run("gradient write accepted after the last pixel was written");
                end
                check_addr("grad_addr", grad_addr, addr_t'(n_writes));
                check_grad("grad_do", grad_do, expected_grad(grad_addr));
                n_writes++;
            end
        end
    end

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    task automatic run_pass(input string label);
        @(posedge clk);
        #1;
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        while (!done) begin
            @(negedge clk);
        end
        // done must hold and nothing more may be read or written
        repeat (DRAIN_CYCLES) @(negedge clk);
        if (n_reads != NPIX) begin
            stop_run($sformatf("%s: only %0d of %0d pixels were read", label, n_reads, NPIX));
        end
        $display("%s: %0d gradient words written", label, n_writes);
    endtask

    initial begin
        seed = 32'h6b79;
        fill_random_image();
        run_pass("random image");
        fill_ramp_image();
        run_pass("ramp image");
        $display("TEST PASS");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_run($sformatf("watchdog expired after %0d cycles", WATCHDOG_CYCLES));
    end

endmodule

// ==== verilog/ig_fetch.sv ====
`timescale 1ns/1ps

module ig_fetch import ig_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  pixel_t    img_di,
    input  logic      out_ready,
    output logic      img_rd,
    output addr_t     img_addr,
    output logic      out_valid,
    output pix_item_t out_item
);

    fetch_state_t state;
    logic [16:0]  cnt;
    logic         armed;
    logic         rd_q;
    logic         hold_valid;
    pix_item_t    hold_item;
    logic         free_next;
    logic         pad_emit;

    // ----------------------------------------
    // output slot
    // ----------------------------------------
    // word returning from memory is presented directly,
    // parked in the hold register only if not taken
    assign out_valid = hold_valid | rd_q;
    assign out_item  = hold_valid ? hold_item : '{pixel: img_di, pad: 1'b0};

    // slot empty next cycle
    assign free_next = !out_valid | out_ready;

    assign img_rd   = armed && (state == FETCH_READ) && free_next;
    assign img_addr = cnt[15:0];
    assign pad_emit = (state == FETCH_PAD) && free_next;

    // ----------------------------------------
    // raster sequencer
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH_READ;
            cnt   <= '0;
            armed <= 1'b0;
        end else begin
            // first cycle out of reset only arms the reader
            armed <= 1'b1;
            if (img_rd) begin
                cnt <= cnt + 17'd1;
                if (cnt == 17'(NPIX - 1)) begin
                    state <= FETCH_PAD;
                end
            end else if (pad_emit) begin
                cnt <= cnt + 17'd1;
                if (cnt == 17'(NPIX + IMG_W - 1)) begin
                    state <= FETCH_DONE;
                end
            end
        end
    end

    // ----------------------------------------
    // hold register
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_q       <= 1'b0;
            hold_valid <= 1'b0;
        end else begin
            rd_q <= img_rd;
            if (rd_q && !out_ready) begin
                hold_valid <= 1'b1;
            end else if (pad_emit) begin
                hold_valid <= 1'b1;
            end else if (out_ready) begin
                hold_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_q && !out_ready) begin
            hold_item <= '{pixel: img_di, pad: 1'b0};
        end else if (pad_emit) begin
            hold_item <= '{pixel: '0, pad: 1'b1};
        end
    end

endmodule

// ==== verilog/ig_gradient.sv ====
`timescale 1ns/1ps

module ig_gradient import ig_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    in_valid,
    input  window_t in_window,
    input  logic    out_ready,
    output logic    in_ready,
    output logic    out_valid,
    output grad_t   out_grad,
    output addr_t   out_addr
);

    grad_comp_t gx;
    grad_comp_t gy;
    logic       last_col;
    logic       last_row;
    logic       accept;

    assign in_ready = !out_valid | out_ready;
    assign accept   = in_valid & in_ready;

    // ----------------------------------------
    // forward differences
    // ----------------------------------------
    // zero-extend to 10 bits, result spans -255..255
    assign gx = $signed({2'b00, in_window.right}) - $signed({2'b00, in_window.center});
    assign gy = $signed({2'b00, in_window.below}) - $signed({2'b00, in_window.center});

    // address low byte is the column, high byte the row
    assign last_col = (in_window.addr[7:0] == 8'(IMG_W - 1));
    assign last_row = (in_window.addr[15:8] == 8'(IMG_H - 1));

    always_ff @(posedge clk) begin
        if (accept) begin
            out_grad.gx <= last_col ? grad_comp_t'(0) : gx;
            out_grad.gy <= last_row ? grad_comp_t'(0) : gy;
            out_addr    <= in_window.addr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

endmodule

// ==== verilog/ig_line_buffer.sv ====
`timescale 1ns/1ps

module ig_line_buffer import ig_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      in_valid,
    input  pix_item_t in_item,
    input  logic      out_ready,
    output logic      in_ready,
    output logic      out_valid,
    output window_t   out_window
);

    // sr[0] is the newest item, sr[IMG_W] the oldest
    pixel_t      sr [0:IMG_W];
    logic [16:0] n_in;
    logic        accept;
    pixel_t      in_pixel;

    // window is only replaced when the current one is gone
    assign in_ready = !out_valid | out_ready;
    assign accept   = in_valid & in_ready;

    // filler beats always shift in as zero
    assign in_pixel = in_item.pad ? pixel_t'(0) : in_item.pixel;

    // ----------------------------------------
    // window taps
    // ----------------------------------------
    // after item k+256 shifts in, the oldest entry is pixel k
    assign out_window = '{
        center: sr[IMG_W],
        right:  sr[IMG_W - 1],
        below:  sr[0],
        addr:   addr_t'(n_in - 17'(IMG_W + 1))
    };

    always_ff @(posedge clk) begin
        if (accept) begin
            sr[0] <= in_pixel;
            for (int i = 1; i <= IMG_W; i++) begin
                sr[i] <= sr[i - 1];
            end
        end
    end

    // ----------------------------------------
    // item count and output flag
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            n_in      <= '0;
            out_valid <= 1'b0;
        end else begin
            if (accept) begin
                n_in <= n_in + 17'd1;
                // first row only primes the buffer
                out_valid <= (n_in >= 17'(IMG_W));
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

endmodule

// ==== verilog/ig_pkg.sv ====
package ig_pkg;

    // ----------------------------------------
    // image geometry
    // ----------------------------------------
    localparam int IMG_W = 256;
    localparam int IMG_H = 256;
    localparam int NPIX  = IMG_W * IMG_H;

    // ----------------------------------------
    // data types
    // ----------------------------------------
    typedef logic [7:0]        pixel_t;
    typedef logic [15:0]       addr_t;
    typedef logic signed [9:0] grad_comp_t;

    // memory word, gx in the upper half
    typedef struct packed {
        grad_comp_t gx;
        grad_comp_t gy;
    } grad_t;

    // pad marks the filler beats after the last image row
    typedef struct packed {
        pixel_t pixel;
        logic   pad;
    } pix_item_t;

    typedef struct packed {
        pixel_t center;
        pixel_t right;
        pixel_t below;
        addr_t  addr;
    } window_t;

    typedef enum logic [1:0] {
        FETCH_READ,
        FETCH_PAD,
        FETCH_DONE
    } fetch_state_t;

endpackage

// ==== verilog/ig_top.sv ====
`timescale 1ns/1ps

module ig_top import ig_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  pixel_t img_di,
    input  logic   grad_ready,
    output logic   img_rd,
    output addr_t  img_addr,
    output logic   grad_wr,
    output addr_t  grad_addr,
    output grad_t  grad_do,
    output logic   done
);

    // fetch to line buffer
    logic      pix_valid;
    logic      pix_ready;
    pix_item_t pix_item;

    // line buffer to gradient
    logic      win_valid;
    logic      win_ready;
    window_t   win;

    // gradient to writeback
    logic      gr_valid;
    logic      gr_ready;
    grad_t     gr;
    addr_t     gr_addr;

    ig_fetch u_fetch (
        .clk       (clk),
        .reset     (reset),
        .img_di    (img_di),
        .out_ready (pix_ready),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .out_valid (pix_valid),
        .out_item  (pix_item)
    );

    ig_line_buffer u_line_buffer (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (pix_valid),
        .in_item    (pix_item),
        .out_ready  (win_ready),
        .in_ready   (pix_ready),
        .out_valid  (win_valid),
        .out_window (win)
    );

    ig_gradient u_gradient (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (win_valid),
        .in_window (win),
        .out_ready (gr_ready),
        .in_ready  (win_ready),
        .out_valid (gr_valid),
        .out_grad  (gr),
        .out_addr  (gr_addr)
    );

    ig_writeback u_writeback (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (gr_valid),
        .in_grad    (gr),
        .in_addr    (gr_addr),
        .grad_ready (grad_ready),
        .in_ready   (gr_ready),
        .grad_wr    (grad_wr),
        .grad_addr  (grad_addr),
        .grad_do    (grad_do),
        .done       (done)
    );

endmodule

// ==== verilog/ig_writeback.sv ====
`timescale 1ns/1ps

module ig_writeback import ig_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  in_valid,
    input  grad_t in_grad,
    input  addr_t in_addr,
    input  logic  grad_ready,
    output logic  in_ready,
    output logic  grad_wr,
    output addr_t grad_addr,
    output grad_t grad_do,
    output logic  done
);

    addr_t wr_cnt;
    logic  accept;
    logic  wr_taken;

    // next word may load while the pending one is being written
    assign in_ready = !grad_wr | grad_ready;
    assign accept   = in_valid & in_ready;
    assign wr_taken = grad_wr & grad_ready;

    // ----------------------------------------
    // pending write
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            grad_addr <= in_addr;
            grad_do   <= in_grad;
        end
    end

    // Write count and sticky done.
    always_ff @(posedge clk) begin
        if (reset) begin
            grad_wr <= 1'b0;
            wr_cnt  <= '0;
            done    <= 1'b0;
        end else begin
            if (accept) begin
                grad_wr <= 1'b1;
            end else if (grad_ready) begin
                grad_wr <= 1'b0;
            end
            if (wr_taken) begin
                wr_cnt <= wr_cnt + 16'd1;
                if (wr_cnt == addr_t'(NPIX - 1)) begin
                    done <= 1'b1;
                end
            end
        end
    end

endmodule
